/* all.f */
src/mem_cfg_pkg.sv
src/mem_req_pkg.sv
src/ram_port_if.sv
src/req_hold.sv
src/byte_lane_unit.sv
src/mem_ctrl_fsm.sv
src/byte_ram.sv
src/mem_subsys_top.sv
tests/mem_subsys_assert.sv
tests/tb_mem_subsys.sv

/* src/byte_lane_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_lane_unit #(
    parameter int addr_w = mem_cfg_pkg::addr_w
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  start,
    input  wire logic                  step,
    input  wire mem_req_pkg::op_kind_t kind,
    input  wire logic [addr_w-1:0]     start_addr,
    input  wire mem_cfg_pkg::word_t    store_word,
    input  wire mem_req_pkg::size_t    size,
    output logic                       last,
    output mem_cfg_pkg::word_t         word,
    ram_port_if.lane                   ram
);

    localparam int cnt_w = $clog2(mem_cfg_pkg::max_bytes + 1);

    logic [cnt_w-1:0]   cnt;
    logic [cnt_w-1:0]   final_cnt;
    logic [addr_w-1:0]  cur_addr;
    mem_req_pkg::size_t size_q;
    mem_cfg_pkg::word_t store_q;
    mem_cfg_pkg::word_t acc;
    logic               reading;

    assign reading = (kind == mem_req_pkg::op_fetch) || (kind == mem_req_pkg::op_load);

    // reads take one extra step, data lags the address by a cycle
    assign final_cnt = reading ? cnt_w'(size_q) : cnt_w'(size_q) - cnt_w'(1);

    assign last = step && (cnt == final_cnt);

    // while stalled the previous address goes out again, so rdata still
    // holds the byte that the next step expects
    assign ram.addr = step ? cur_addr : cur_addr - 1'b1;

    assign ram.wdata = mem_cfg_pkg::byte_t'(store_q >> (8 * cnt));

    // byte cnt-1 arrives now, little-endian slot
    always_comb begin
        word = acc;
        if (step && reading && (cnt != '0)) begin
            word[8*(cnt-1) +: 8] = ram.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= '0;
        end else if (step) begin
            cnt <= cnt + 1'b1;
        end
    end

    // cleared acc gives the zero fill of unused upper bytes
    always_ff @(posedge clk) begin
        if (start) begin
            cur_addr <= start_addr;
            size_q   <= size;
            store_q  <= store_word;
            acc      <= '0;
        end else if (step) begin
            cur_addr <= cur_addr + 1'b1;
            acc      <= word;
        end
    end

endmodule

`default_nettype wire

/* src/byte_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_ram #(
    parameter int addr_w    = mem_cfg_pkg::addr_w,
    parameter int ram_depth = mem_cfg_pkg::ram_depth
) (
    input  wire logic clk,
    ram_port_if.ram   ram
);

    // upper address bits beyond the array are ignored
    localparam int idx_w = ($clog2(ram_depth) < addr_w) ? $clog2(ram_depth) : addr_w;

    mem_cfg_pkg::byte_t mem [ram_depth];
    logic [idx_w-1:0]   idx;

    assign idx = ram.addr[idx_w-1:0];

    // read data is registered every cycle, old byte on a write
    always_ff @(posedge clk) begin
        if (ram.wr) begin
            mem[idx] <= ram.wdata;
        end
        ram.rdata <= mem[idx];
    end

endmodule

`default_nettype wire

/* src/mem_cfg_pkg.sv */
`default_nettype none

package mem_cfg_pkg;

    // byte address into the RAM
    localparam int addr_w = 17;
    localparam int data_w = 32;
    localparam int byte_w = 8;

    // size of the RAM model in bytes
    localparam int ram_depth = 1024;

    // widest access in bytes
    localparam int max_bytes = data_w / byte_w;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] word_t;
    typedef logic [byte_w-1:0] byte_t;

endpackage

`default_nettype wire

/* src/mem_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl_fsm #(
    parameter int addr_w = mem_cfg_pkg::addr_w
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    fetch_ena,
    input  wire logic [addr_w-1:0]       fetch_pc,
    input  wire logic                    ls_ena,
    input  wire mem_req_pkg::ls_req_t    ls_req,
    input  wire logic                    drop,

    // pending request holders
    input  wire logic                    fetch_full,
    input  wire mem_req_pkg::fetch_req_t fetch_held,
    input  wire logic                    ls_full,
    input  wire mem_req_pkg::ls_req_t    ls_held,
    output logic                         fetch_capture,
    output logic                         fetch_take,
    output logic                         fetch_flush,
    output logic                         ls_capture,
    output logic                         ls_take,
    output logic                         ls_flush,

    // byte lane unit
    output logic                         lane_start,
    output logic                         lane_step,
    output mem_req_pkg::op_kind_t        lane_kind,
    output logic [addr_w-1:0]            lane_addr,
    output mem_cfg_pkg::word_t           lane_wdata,
    output mem_req_pkg::size_t           lane_size,
    input  wire logic                    lane_last,

    ram_port_if.ctrl                     ram,

    output logic                         ok_fetch,
    output logic                         ok_ls
);

    mem_req_pkg::op_kind_t state;
    mem_req_pkg::op_kind_t state_nx;
    mem_req_pkg::op_kind_t sel_kind;
    mem_req_pkg::ls_req_t  sel_req;

    logic busy;
    logic dropping;
    logic free;
    logic ls_pend;
    logic fetch_pend;
    logic go_ls_new;
    logic go_ls_pend;
    logic go_fetch_new;
    logic go_fetch_pend;

    assign busy     = (state != mem_req_pkg::op_idle);
    assign dropping = drop && ((state == mem_req_pkg::op_fetch) ||
                               (state == mem_req_pkg::op_load));
    // a dropped fetch or load frees the port in the same cycle
    assign free     = !busy || dropping;

    // drop already discards pending loads and fetches here
    assign ls_pend    = ls_full && !(drop && !ls_held.wr);
    assign fetch_pend = fetch_full && !drop;

    // new ls, pending ls, new fetch, pending fetch
    assign go_ls_new     = free && ls_ena;
    assign go_ls_pend    = free && !ls_ena && ls_pend;
    assign go_fetch_new  = free && !ls_ena && !ls_pend && fetch_ena;
    assign go_fetch_pend = free && !ls_ena && !ls_pend && !fetch_ena && fetch_pend;

    // losers and late arrivals get parked
    assign ls_capture    = ls_ena && !go_ls_new;
    assign ls_take       = go_ls_pend;
    assign ls_flush      = drop;
    assign fetch_capture = fetch_ena && !go_fetch_new;
    assign fetch_take    = go_fetch_pend;
    assign fetch_flush   = drop;

    always_comb begin
        sel_req  = ls_held;
        sel_kind = mem_req_pkg::op_idle;
        if (go_ls_new || go_ls_pend) begin
            if (go_ls_new) begin
                sel_req = ls_req;
            end
            sel_kind = sel_req.wr ? mem_req_pkg::op_store : mem_req_pkg::op_load;
        end else if (go_fetch_new || go_fetch_pend) begin
            sel_req.wr   = 1'b0;
            sel_req.size = mem_req_pkg::size_word;
            sel_req.addr = go_fetch_new ? fetch_pc : fetch_held.addr;
            sel_req.data = '0;
            sel_kind     = mem_req_pkg::op_fetch;
        end
    end

    assign lane_start = go_ls_new || go_ls_pend || go_fetch_new || go_fetch_pend;
    assign lane_addr  = sel_req.addr;
    assign lane_wdata = sel_req.data;
    assign lane_size  = sel_req.size;
    assign lane_kind  = state;

    // stall freezes everything on the byte side
    assign lane_step = busy && !dropping && !ram.stall;
    assign ram.wr    = (state == mem_req_pkg::op_store) && !ram.stall;

    always_comb begin
        state_nx = state;
        if (lane_start) begin
            state_nx = sel_kind;
        end else if (dropping || lane_last) begin
            state_nx = mem_req_pkg::op_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= mem_req_pkg::op_idle;
            ok_fetch <= 1'b0;
            ok_ls    <= 1'b0;
        end else begin
            state    <= state_nx;
            ok_fetch <= lane_last && (state == mem_req_pkg::op_fetch);
            ok_ls    <= lane_last && ((state == mem_req_pkg::op_load) ||
                                      (state == mem_req_pkg::op_store));
        end
    end

endmodule

`default_nettype wire

/* src/mem_req_pkg.sv */
`default_nettype none

package mem_req_pkg;

    // access size in bytes
    typedef logic [2:0] size_t;

    localparam size_t size_byte = 3'd1;
    localparam size_t size_half = 3'd2;
    localparam size_t size_word = 3'd4;

    // controller state, also the byte direction for the lane unit
    typedef enum logic [1:0] {
        op_idle,
        op_fetch,
        op_load,
        op_store
    } op_kind_t;

    typedef struct packed {
        mem_cfg_pkg::addr_t addr;
    } fetch_req_t;

    // wr has to stay the top bit, req_hold looks for it there
    typedef struct packed {
        logic               wr;
        size_t              size;
        mem_cfg_pkg::addr_t addr;
        mem_cfg_pkg::word_t data;
    } ls_req_t;

endpackage

`default_nettype wire

/* src/mem_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
    parameter int addr_w    = mem_cfg_pkg::addr_w,
    parameter int ram_depth = mem_cfg_pkg::ram_depth
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               stall,
    input  wire logic               fetch_ena,
    input  wire logic [addr_w-1:0]  fetch_pc,
    input  wire logic               drop,
    input  wire logic               ls_ena,
    input  wire logic               ls_wr,
    input  wire mem_req_pkg::size_t ls_size,
    input  wire logic [addr_w-1:0]  ls_addr,
    input  wire mem_cfg_pkg::word_t ls_wdata,
    output logic                    ok_fetch,
    output mem_cfg_pkg::word_t      inst,
    output logic                    ok_ls,
    output mem_cfg_pkg::word_t      ls_rdata
);

    mem_req_pkg::ls_req_t    ls_req;
    mem_req_pkg::ls_req_t    ls_held;
    mem_req_pkg::fetch_req_t fetch_req;
    mem_req_pkg::fetch_req_t fetch_held;

    logic fetch_full;
    logic fetch_capture;
    logic fetch_take;
    logic fetch_flush;
    logic ls_full;
    logic ls_capture;
    logic ls_take;
    logic ls_flush;

    logic                  lane_start;
    logic                  lane_step;
    logic                  lane_last;
    mem_req_pkg::op_kind_t lane_kind;
    logic [addr_w-1:0]     lane_addr;
    mem_cfg_pkg::word_t    lane_wdata;
    mem_cfg_pkg::word_t    lane_word;
    mem_req_pkg::size_t    lane_size;

    ram_port_if #(.addr_w(addr_w)) ram_if ();

    assign ram_if.stall = stall;

    assign ls_req    = '{wr: ls_wr, size: ls_size, addr: ls_addr, data: ls_wdata};
    assign fetch_req = '{addr: fetch_pc};

    // one assembly register serves both clients, ok tells whose it is
    assign inst     = lane_word;
    assign ls_rdata = lane_word;

    mem_ctrl_fsm #(.addr_w(addr_w)) ctrl_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_ena     (fetch_ena),
        .fetch_pc      (fetch_pc),
        .ls_ena        (ls_ena),
        .ls_req        (ls_req),
        .drop          (drop),
        .fetch_full    (fetch_full),
        .fetch_held    (fetch_held),
        .ls_full       (ls_full),
        .ls_held       (ls_held),
        .fetch_capture (fetch_capture),
        .fetch_take    (fetch_take),
        .fetch_flush   (fetch_flush),
        .ls_capture    (ls_capture),
        .ls_take       (ls_take),
        .ls_flush      (ls_flush),
        .lane_start    (lane_start),
        .lane_step     (lane_step),
        .lane_kind     (lane_kind),
        .lane_addr     (lane_addr),
        .lane_wdata    (lane_wdata),
        .lane_size     (lane_size),
        .lane_last     (lane_last),
        .ram           (ram_if.ctrl),
        .ok_fetch      (ok_fetch),
        .ok_ls         (ok_ls)
    );

    req_hold #(
        .payload_t            (mem_req_pkg::fetch_req_t),
        .keep_on_flush_fn_sel (1'b0)
    ) fetch_hold_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .capture  (fetch_capture),
        .take     (fetch_take),
        .flush    (fetch_flush),
        .data_in  (fetch_req),
        .full     (fetch_full),
        .data_out (fetch_held)
    );

    // pending stores outlive a drop
    req_hold #(
        .payload_t            (mem_req_pkg::ls_req_t),
        .keep_on_flush_fn_sel (1'b1)
    ) ls_hold_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .capture  (ls_capture),
        .take     (ls_take),
        .flush    (ls_flush),
        .data_in  (ls_req),
        .full     (ls_full),
        .data_out (ls_held)
    );

    byte_lane_unit #(.addr_w(addr_w)) lane_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (lane_start),
        .step       (lane_step),
        .kind       (lane_kind),
        .start_addr (lane_addr),
        .store_word (lane_wdata),
        .size       (lane_size),
        .last       (lane_last),
        .word       (lane_word),
        .ram        (ram_if.lane)
    );

    byte_ram #(
        .addr_w    (addr_w),
        .ram_depth (ram_depth)
    ) ram_inst (
        .clk (clk),
        .ram (ram_if.ram)
    );

endmodule

`default_nettype wire

/* src/ram_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface ram_port_if #(
    parameter int addr_w = mem_cfg_pkg::addr_w
);
    logic [addr_w-1:0]  addr;
    mem_cfg_pkg::byte_t wdata;
    logic               wr;
    mem_cfg_pkg::byte_t rdata;
    // RAM side buffer full
    logic               stall;

    modport lane (
        output addr,
        output wdata,
        input  rdata
    );

    modport ctrl (
        output wr,
        input  stall
    );

    modport ram (
        input  addr,
        input  wdata,
        input  wr,
        output rdata
    );

endinterface

`default_nettype wire

/* src/req_hold.sv */
`timescale 1ns/1ps
`default_nettype none

module req_hold #(
    parameter type payload_t            = logic [31:0],
    parameter bit  keep_on_flush_fn_sel = 1'b0
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     capture,
    input  wire logic     take,
    input  wire logic     flush,
    input  wire payload_t data_in,
    output logic          full,
    output payload_t      data_out
);

    logic keep;

    // a held store survives a flush
    assign keep = keep_on_flush_fn_sel && data_out[$bits(payload_t)-1];

    // new request wins over a flush in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (capture) begin
            full <= 1'b1;
        end else if (take) begin
            full <= 1'b0;
        end else if (flush && !keep) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_out <= data_in;
        end
    end

endmodule

`default_nettype wire

/* tests/mem_subsys_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_assert (
    input wire logic                  clk,
    input wire logic                  rst_n,
    input wire logic                  ok_fetch,
    input wire logic                  ok_ls,
    input wire logic                  wr,
    input wire mem_req_pkg::op_kind_t state
);

    int fail_cnt = 0;

    ok_one_client: assert property (@(posedge clk) disable iff (!rst_n)
        !(ok_fetch && ok_ls))
        else begin
            $error("ok_fetch and ok_ls high in the same cycle");
            fail_cnt++;
        end

    ok_fetch_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ok_fetch |=> !ok_fetch)
        else begin
            $error("ok_fetch held longer than one cycle");
            fail_cnt++;
        end

    ok_ls_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ok_ls |=> !ok_ls)
        else begin
            $error("ok_ls held longer than one cycle");
            fail_cnt++;
        end

    no_write_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == mem_req_pkg::op_idle) |-> !wr)
        else begin
            $error("RAM write enable high while the controller is idle");
            fail_cnt++;
        end

endmodule

bind mem_ctrl_fsm mem_subsys_assert ctrl_assert_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .ok_fetch (ok_fetch),
    .ok_ls    (ok_ls),
    .wr       (ram.wr),
    .state    (state)
);

`default_nettype wire

/* tests/tb_mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

    localparam int span  = 256;
    localparam int limit = 400;

    logic               clk;
    logic               rst_n;
    logic               stall;
    logic               fetch_ena;
    mem_cfg_pkg::addr_t fetch_pc;
    logic               drop;
    logic               ls_ena;
    logic               ls_wr;
    mem_req_pkg::size_t ls_size;
    mem_cfg_pkg::addr_t ls_addr;
    mem_cfg_pkg::word_t ls_wdata;
    logic               ok_fetch;
    mem_cfg_pkg::word_t inst;
    logic               ok_ls;
    mem_cfg_pkg::word_t ls_rdata;

    mem_cfg_pkg::byte_t shadow [span];
    mem_cfg_pkg::word_t ls_word;
    mem_cfg_pkg::word_t f_word;
    logic [31:0]        seed = 32'd98;
    logic [31:0]        stall_seed;
    logic               stall_on = 1'b0;
    int                 errors = 0;
    int                 passed = 0;
    int                 failed = 0;
    int                 n_ls = 0;
    int                 n_fetch = 0;
    int                 ls_at;
    int                 f_at;

    mem_subsys_top mem_subsys_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ok pulses as the clients see them
    always @(posedge clk) begin
        if (ok_ls) begin
            n_ls++;
        end
        if (ok_fetch) begin
            n_fetch++;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int error_total();
        return errors + mem_subsys_top_inst.ctrl_inst.ctrl_assert_inst.fail_cnt;
    endfunction

    task automatic draw(input int range, output int v);
        seed = lcg_next(seed);
        v = int'(seed[30:8]) % range;
    endtask

    // falling edge, new stall value when enabled
    task automatic cycle();
        @(negedge clk);
        stall_seed = lcg_next(stall_seed);
        stall = stall_on && (stall_seed[17:16] == 2'b00);
    endtask

    function automatic mem_cfg_pkg::word_t model_read(input int addr, input int n);
        mem_cfg_pkg::word_t w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w[8*i +: 8] = shadow[addr + i];
        end
        return w;
    endfunction

    task automatic model_write(input int addr, input int n, input mem_cfg_pkg::word_t d);
        for (int i = 0; i < n; i++) begin
            shadow[addr + i] = d[8*i +: 8];
        end
    endtask

    task automatic put_ls(input logic wr, input int addr, input int n,
                          input mem_cfg_pkg::word_t data);
        ls_ena   = 1'b1;
        ls_wr    = wr;
        ls_size  = mem_req_pkg::size_t'(n);
        ls_addr  = mem_cfg_pkg::addr_t'(addr);
        ls_wdata = data;
    endtask

    task automatic put_fetch(input int addr);
        fetch_ena = 1'b1;
        fetch_pc  = mem_cfg_pkg::addr_t'(addr);
    endtask

    // request strobes last one cycle, data captured while ok is high
    task automatic await_ok(input logic need_ls, input logic need_fetch);
        int n;
        n     = 0;
        ls_at = -1;
        f_at  = -1;
        while (((need_ls && ls_at < 0) || (need_fetch && f_at < 0)) && n < limit) begin
            cycle();
            n++;
            fetch_ena = 1'b0;
            ls_ena    = 1'b0;
            drop      = 1'b0;
            if (ok_ls && ls_at < 0) begin
                ls_at   = n;
                ls_word = ls_rdata;
            end
            if (ok_fetch && f_at < 0) begin
                f_at   = n;
                f_word = inst;
            end
        end
        assert (!((need_ls && ls_at < 0) || (need_fetch && f_at < 0))) else begin
            $display("Timeout at %0t: an expected ok pulse never arrived", $time);
            errors++;
        end
    endtask

    task automatic check(input string name, input mem_cfg_pkg::word_t exp,
                         input mem_cfg_pkg::word_t got);
        assert (got === exp) else begin
            $display("Fail at time %0t: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int got);
        assert (got == exp) else begin
            $display("Fail at time %0t: %s expected %0d got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic draw_access(output int addr, output int n, output mem_cfg_pkg::word_t data);
        int k;
        int hi;
        int lo;
        draw(span - 3, addr);
        draw(3, k);
        draw(65536, hi);
        draw(65536, lo);
        n    = (k == 2) ? 4 : k + 1;
        data = {hi[15:0], lo[15:0]};
    endtask

    task automatic store_load();
        int                 addr;
        int                 n;
        mem_cfg_pkg::word_t data;
        draw_access(addr, n, data);
        put_ls(1'b1, addr, n, data);
        await_ok(1'b1, 1'b0);
        model_write(addr, n, data);
        put_ls(1'b0, addr, n, '0);
        await_ok(1'b1, 1'b0);
        check("ls_rdata", model_read(addr, n), ls_word);
    endtask

    task automatic fetch_one();
        int addr;
        draw(span - 3, addr);
        put_fetch(addr);
        await_ok(1'b0, 1'b1);
        check("inst", model_read(addr, 4), f_word);
    endtask

    // let the last ok reach the counters first
    task automatic mark(output int base, output int ls0, output int f0);
        repeat (2) cycle();
        base = error_total();
        ls0  = n_ls;
        f0   = n_fetch;
    endtask

    task automatic end_test(input string name, input int base);
        if (error_total() == base) begin
            passed++;
            $display("%s: pass", name);
        end else begin
            failed++;
            $display("%s: fail, %0d errors", name, error_total() - base);
        end
    endtask

    initial begin
        int                 base;
        int                 ls0;
        int                 f0;
        int                 addr;
        int                 n;
        int                 fa;
        int                 fb;
        logic               wr;
        mem_cfg_pkg::word_t data;
        rst_n      = 1'b0;
        stall      = 1'b0;
        fetch_ena  = 1'b0;
        fetch_pc   = '0;
        drop       = 1'b0;
        ls_ena     = 1'b0;
        ls_wr      = 1'b0;
        ls_size    = '0;
        ls_addr    = '0;
        ls_wdata   = '0;
        stall_seed = lcg_next(seed);
        repeat (10) cycle();
        rst_n = 1'b1;

        // RAM region and shadow start out zero together
        for (int a = 0; a < span; a += 4) begin
            put_ls(1'b1, a, 4, '0);
            await_ok(1'b1, 1'b0);
            model_write(a, 4, '0);
        end

        mark(base, ls0, f0);
        repeat (20) store_load();
        end_test("test 1 stores then loads", base);

        mark(base, ls0, f0);
        repeat (20) fetch_one();
        end_test("test 2 fetches", base);

        mark(base, ls0, f0);
        stall_on = 1'b1;
        repeat (15) begin
            store_load();
            fetch_one();
        end
        stall_on = 1'b0;
        repeat (4) cycle();
        check_count("ok_ls count", ls0 + 30, n_ls);
        check_count("ok_fetch count", f0 + 15, n_fetch);
        end_test("test 3 random stall", base);

        mark(base, ls0, f0);
        repeat (8) begin
            draw_access(addr, n, data);
            draw(span - 3, fa);
            wr = data[0];
            put_fetch(fa);
            put_ls(wr, addr, n, data);
            await_ok(1'b1, 1'b1);
            if (wr) begin
                model_write(addr, n, data);
            end else begin
                check("ls_rdata", model_read(addr, n), ls_word);
            end
            check("inst", model_read(fa, 4), f_word);
            assert (ls_at < f_at) else begin
                $display("At %0t the fetch ok came before the load/store ok", $time);
                errors++;
            end
        end
        repeat (4) cycle();
        check_count("ok_ls count", ls0 + 8, n_ls);
        check_count("ok_fetch count", f0 + 8, n_fetch);
        end_test("test 4 fetch and load/store together", base);

        mark(base, ls0, f0);
        repeat (4) begin
            draw_access(addr, n, data);
            draw(span - 3, fa);
            draw(span - 3, fb);
            put_fetch(fa);
            cycle();
            fetch_ena = 1'b0;
            // store parks behind the running fetch
            put_ls(1'b1, addr, n, data);
            cycle();
            ls_ena = 1'b0;
            drop   = 1'b1;
            put_fetch(fb);
            await_ok(1'b1, 1'b1);
            model_write(addr, n, data);
            check("inst", model_read(fb, 4), f_word);
            put_ls(1'b0, addr, n, '0);
            await_ok(1'b1, 1'b0);
            check("ls_rdata", model_read(addr, n), ls_word);
        end
        repeat (4) cycle();
        check_count("ok_ls count", ls0 + 8, n_ls);
        check_count("ok_fetch count", f0 + 4, n_fetch);
        end_test("test 5 drop during fetch", base);

        $display("tests passed: %0d, failed: %0d", passed, failed);
        if (failed == 0 && error_total() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
